// ==== design/int_pkg.sv ====
package int_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes and constants
  localparam int INT_LATENCY = 4;   // Register stages through int_math
  localparam int FIFO_DEPTH  = 16;  // Kept a power of two so pointers wrap on their own
  localparam int FIFO_CNT_W  = 5;   // Wide enough to hold FIFO_DEPTH itself
  localparam int EPS_SHIFT   = 8;   // Epsilon is 2**-EPS_SHIFT of the denominator
  localparam int RAY_SLOTS   = 16;
  localparam int FRAC_BITS   = 8;   // Fraction bits of coord_t

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scalar types
  typedef logic signed [15:0] coord_t;  // Signed 8.8 fixed point
  typedef logic signed [31:0] prod_t;   // Product of two coordinates, 16 fraction bits
  typedef logic signed [47:0] wide_t;   // Cross product terms and their sums
  typedef logic [3:0] ray_id_t;
  typedef logic [15:0] tri_id_t;
  typedef logic [7:0] lcount_t;         // Triangles still to come in this leaf list
  typedef logic [15:0] lindex_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Structures
  typedef struct packed {
    coord_t ox, oy, oz;  // Origin
    coord_t dx, dy, dz;  // Direction
  } ray_vec_t;

  // Maps world space onto the unit triangle (0,0) (1,0) (0,1) in z = 0
  typedef struct packed {
    coord_t m00, m01, m02;
    coord_t m10, m11, m12;
    coord_t m20, m21, m22;
    coord_t tx, ty, tz;
  } tri_xform_t;

  typedef struct packed {
    lcount_t lnum_left;
    lindex_t lindex;
  } ln_tri_t;

  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
    ln_tri_t ln_tri;
    tri_xform_t tri_xform;
    ray_vec_t ray_vec;
  } rs_to_int_t;

  // t, u and v all share t_den, which is positive whenever hit is set
  typedef struct packed {
    ray_id_t ray_id;
    tri_id_t tri_id;
    logic hit;
    logic is_last;
    wide_t t_num;
    wide_t t_den;
    wide_t u_num;
    wide_t v_num;
  } int_to_list_t;

  typedef struct packed {
    ray_id_t ray_id;
    ln_tri_t ln_tri;
  } leaf_info_t;

  typedef struct packed {
    leaf_info_t leaf;
    tri_id_t tri_id;
  } pipe_item_t;

  typedef struct packed {
    ray_id_t ray_id;
    logic hit;
    tri_id_t tri_id;
    wide_t t_num;
    wide_t t_den;
    wide_t u_num;
    wide_t v_num;
  } ray_result_t;

endpackage

// ==== design/int_math.sv ====
module int_math (
  input  logic clk,
  input  logic reset,
  input  int_pkg::tri_xform_t tri_xform,
  input  int_pkg::ray_vec_t ray_vec,
  output logic hit,
  output int_pkg::wide_t t_num,
  output int_pkg::wide_t t_den,
  output int_pkg::wide_t u_num,
  output int_pkg::wide_t v_num
);

  // One matrix row times a vector, rescaled back to 8.8
  function automatic int_pkg::coord_t dot3(
    input int_pkg::coord_t a,
    input int_pkg::coord_t b,
    input int_pkg::coord_t c,
    input int_pkg::coord_t x,
    input int_pkg::coord_t y,
    input int_pkg::coord_t z
  );
    int_pkg::wide_t acc;
    acc = a * x + b * y + c * z;
    return int_pkg::coord_t'(acc >>> int_pkg::FRAC_BITS);
  endfunction

  int_pkg::ray_vec_t xr1;  // Ray in unit triangle space
  int_pkg::prod_t ox_dz, oz_dx, oy_dz, oz_dy;
  int_pkg::wide_t t_num2, t_den2, u_num2, v_num2;
  int_pkg::wide_t t_num3, t_den3, u_num3, v_num3;
  int_pkg::wide_t uv_sum;
  logic flip;
  logic hit4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 1 applies the matrix, and the translation to the origin only
  always_ff @(posedge clk) begin
    xr1.ox <= dot3(tri_xform.m00, tri_xform.m01, tri_xform.m02,
                   ray_vec.ox, ray_vec.oy, ray_vec.oz) + tri_xform.tx;
    xr1.oy <= dot3(tri_xform.m10, tri_xform.m11, tri_xform.m12,
                   ray_vec.ox, ray_vec.oy, ray_vec.oz) + tri_xform.ty;
    xr1.oz <= dot3(tri_xform.m20, tri_xform.m21, tri_xform.m22,
                   ray_vec.ox, ray_vec.oy, ray_vec.oz) + tri_xform.tz;
    xr1.dx <= dot3(tri_xform.m00, tri_xform.m01, tri_xform.m02,
                   ray_vec.dx, ray_vec.dy, ray_vec.dz);
    xr1.dy <= dot3(tri_xform.m10, tri_xform.m11, tri_xform.m12,
                   ray_vec.dx, ray_vec.dy, ray_vec.dz);
    xr1.dz <= dot3(tri_xform.m20, tri_xform.m21, tri_xform.m22,
                   ray_vec.dx, ray_vec.dy, ray_vec.dz);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 2 solves oz + t*dz = 0 without dividing by dz
  assign ox_dz = xr1.ox * xr1.dz;
  assign oz_dx = xr1.oz * xr1.dx;
  assign oy_dz = xr1.oy * xr1.dz;
  assign oz_dy = xr1.oz * xr1.dy;

  // Everything is brought to 16 fraction bits so the four terms compare directly
  always_ff @(posedge clk) begin
    t_num2 <= -(int_pkg::wide_t'(xr1.oz) <<< int_pkg::FRAC_BITS);
    t_den2 <= int_pkg::wide_t'(xr1.dz) <<< int_pkg::FRAC_BITS;
    u_num2 <= ox_dz - oz_dx;  // u * dz
    v_num2 <= oy_dz - oz_dy;  // v * dz
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 3 makes the denominator positive
  assign flip = (t_den2 < 0);

  always_ff @(posedge clk) begin
    t_num3 <= flip ? -t_num2 : t_num2;
    t_den3 <= flip ? -t_den2 : t_den2;
    u_num3 <= flip ? -u_num2 : u_num2;
    v_num3 <= flip ? -v_num2 : v_num2;
  end

  // Stage 4 is the scaled epsilon and barycentric test
  assign uv_sum = u_num3 + v_num3;
  assign hit4 = (t_den3 > 0)                                  // A parallel ray never hits
              && (t_num3 > (t_den3 >>> int_pkg::EPS_SHIFT))
              && (u_num3 >= 0)
              && (v_num3 >= 0)
              && (uv_sum <= t_den3);

  always_ff @(posedge clk) begin
    if (reset) begin
      hit <= 1'b0;
    end else begin
      hit <= hit4;
    end
  end

  always_ff @(posedge clk) begin
    t_num <= t_num3;
    t_den <= t_den3;
    u_num <= u_num3;
    v_num <= v_num3;
  end

endmodule

// ==== design/pipe_valid_stall.sv ====
module pipe_valid_stall (
  input  logic clk,
  input  logic reset,
  input  logic us_valid,
  input  int_pkg::pipe_item_t us_data,
  input  int_pkg::fifo_cnt_t ds_space,
  output logic us_stall,
  output logic ds_valid,
  output int_pkg::pipe_item_t ds_data
);

  logic [int_pkg::INT_LATENCY-1:0] stage_valid;
  int_pkg::pipe_item_t stage_data [int_pkg::INT_LATENCY];
  int_pkg::fifo_cnt_t in_flight;  // Number of set bits in stage_valid
  logic accept;

  // Every item in flight may need one slot in each FIFO when it lands
  assign us_stall = (ds_space <= in_flight);
  assign accept = us_valid & ~us_stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= '0;
      in_flight   <= '0;
    end else begin
      stage_valid <= {stage_valid[int_pkg::INT_LATENCY-2:0], accept};
      in_flight   <= in_flight
                   + int_pkg::fifo_cnt_t'(accept)
                   - int_pkg::fifo_cnt_t'(stage_valid[int_pkg::INT_LATENCY-1]);
    end
  end

  // Data shifts every cycle alongside int_math and never waits
  always_ff @(posedge clk) begin
    stage_data[0] <= us_data;
    for (int i = 1; i < int_pkg::INT_LATENCY; i++) begin
      stage_data[i] <= stage_data[i-1];
    end
  end

  assign ds_valid = stage_valid[int_pkg::INT_LATENCY-1];
  assign ds_data  = stage_data[int_pkg::INT_LATENCY-1];

endmodule

// ==== design/sync_fifo.sv ====
module sync_fifo #(
  parameter type item_t = logic
) (
  input  logic clk,
  input  logic reset,
  input  logic wr_en,
  input  item_t wr_data,
  input  logic rd_en,
  output item_t rd_data,
  output logic empty,
  output logic full,
  output int_pkg::fifo_cnt_t used
);

  item_t mem [int_pkg::FIFO_DEPTH];
  logic [$clog2(int_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(int_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  assign full  = (used == int_pkg::fifo_cnt_t'(int_pkg::FIFO_DEPTH));
  assign empty = (used == '0);

  assign do_wr = wr_en & ~full;   // Writes to a full FIFO are dropped
  assign do_rd = rd_en & ~empty;

  // Head entry shows at the output without a read request
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      used <= used + int_pkg::fifo_cnt_t'(do_wr) - int_pkg::fifo_cnt_t'(do_rd);
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== design/int_unit.sv ====
module int_unit (
  input  logic clk,
  input  logic reset,
  input  logic rs_to_int_valid,
  input  int_pkg::rs_to_int_t rs_to_int_data,
  output logic rs_to_int_stall,
  output logic int_to_list_valid,
  output int_pkg::int_to_list_t int_to_list_data,
  input  logic int_to_list_stall,
  output logic int_to_larb_valid,
  output int_pkg::leaf_info_t int_to_larb_data,
  input  logic int_to_larb_stall
);

  logic hit;
  int_pkg::wide_t t_num, t_den, u_num, v_num;

  int_pkg::pipe_item_t pipe_in, pipe_out;
  logic pipe_valid;
  logic pipe_us_stall;

  int_pkg::fifo_cnt_t list_used, larb_used;
  int_pkg::fifo_cnt_t list_space, larb_space, min_space;
  logic list_full, larb_full;
  logic list_empty, larb_empty;
  logic list_wr, larb_wr;
  logic list_rd, larb_rd;
  logic is_last;
  int_pkg::int_to_list_t list_in;

  int_math int_math_inst (
    .clk,
    .reset,
    .tri_xform(rs_to_int_data.tri_xform),
    .ray_vec(rs_to_int_data.ray_vec),
    .hit,
    .t_num,
    .t_den,
    .u_num,
    .v_num
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // List bookkeeping happens before the delay line
  always_comb begin
    pipe_in.tri_id = rs_to_int_data.tri_id;
    pipe_in.leaf.ray_id = rs_to_int_data.ray_id;
    pipe_in.leaf.ln_tri.lnum_left = rs_to_int_data.ln_tri.lnum_left - int_pkg::lcount_t'(1);
    pipe_in.leaf.ln_tri.lindex = rs_to_int_data.ln_tri.lindex + int_pkg::lindex_t'(1);
  end

  // The tighter FIFO decides admission
  assign list_space = int_pkg::fifo_cnt_t'(int_pkg::FIFO_DEPTH) - list_used;
  assign larb_space = int_pkg::fifo_cnt_t'(int_pkg::FIFO_DEPTH) - larb_used;
  assign min_space  = (list_space < larb_space) ? list_space : larb_space;

  pipe_valid_stall pipe_inst (
    .clk,
    .reset,
    .us_valid(rs_to_int_valid),
    .us_data(pipe_in),
    .ds_space(min_space),
    .us_stall(pipe_us_stall),
    .ds_valid(pipe_valid),
    .ds_data(pipe_out)
  );

  assign rs_to_int_stall = pipe_us_stall & rs_to_int_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Delay line output lines up with the math result
  assign is_last = (pipe_out.leaf.ln_tri.lnum_left == '0);
  assign list_wr = pipe_valid & (hit | is_last);  // Misses only matter to close a list
  assign larb_wr = pipe_valid & ~is_last;

  always_comb begin
    list_in.ray_id  = pipe_out.leaf.ray_id;
    list_in.tri_id  = pipe_out.tri_id;
    list_in.hit     = hit;
    list_in.is_last = is_last;
    list_in.t_num   = t_num;
    list_in.t_den   = t_den;
    list_in.u_num   = u_num;
    list_in.v_num   = v_num;
  end

  sync_fifo #(.item_t(int_pkg::int_to_list_t)) list_fifo_inst (
    .clk,
    .reset,
    .wr_en(list_wr),
    .wr_data(list_in),
    .rd_en(list_rd),
    .rd_data(int_to_list_data),
    .empty(list_empty),
    .full(list_full),
    .used(list_used)
  );

  sync_fifo #(.item_t(int_pkg::leaf_info_t)) larb_fifo_inst (
    .clk,
    .reset,
    .wr_en(larb_wr),
    .wr_data(pipe_out.leaf),
    .rd_en(larb_rd),
    .rd_data(int_to_larb_data),
    .empty(larb_empty),
    .full(larb_full),
    .used(larb_used)
  );

  assign int_to_list_valid = ~list_empty;
  assign list_rd = int_to_list_valid & ~int_to_list_stall;
  assign int_to_larb_valid = ~larb_empty;
  assign larb_rd = int_to_larb_valid & ~int_to_larb_stall;

endmodule

// ==== design/hit_list.sv ====
module hit_list (
  input  logic clk,
  input  logic reset,
  input  logic list_valid,
  input  int_pkg::int_to_list_t list_data,
  output logic list_stall,
  input  logic result_stall,
  output logic result_valid,
  output int_pkg::ray_result_t result_data
);

  logic [int_pkg::RAY_SLOTS-1:0] slot_hit;       // Slot holds a hit for its ray
  int_pkg::ray_result_t slot_rec [int_pkg::RAY_SLOTS];
  int_pkg::ray_result_t cur_rec, new_rec, result_next;
  logic signed [2*$bits(int_pkg::wide_t)-1:0] new_cross, old_cross;
  logic cur_hit;
  logic closer;
  logic replace;
  logic take;

  // Entries only wait when a finished result is still parked
  assign list_stall = result_valid & result_stall;
  assign take = list_valid & ~list_stall;

  assign cur_rec = slot_rec[list_data.ray_id];
  assign cur_hit = slot_hit[list_data.ray_id];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Both denominators are positive so the fractions compare by cross products
  assign new_cross = list_data.t_num * cur_rec.t_den;
  assign old_cross = cur_rec.t_num * list_data.t_den;
  assign closer = (new_cross < old_cross);  // A tie keeps the earlier hit
  assign replace = list_data.hit & (~cur_hit | closer);

  always_comb begin
    new_rec.ray_id = list_data.ray_id;
    new_rec.hit    = 1'b1;
    new_rec.tri_id = list_data.tri_id;
    new_rec.t_num  = list_data.t_num;
    new_rec.t_den  = list_data.t_den;
    new_rec.u_num  = list_data.u_num;
    new_rec.v_num  = list_data.v_num;

    if (replace) begin
      result_next = new_rec;
    end else if (cur_hit) begin
      result_next = cur_rec;
    end else begin
      result_next = '0;  // Ray missed every triangle in its list
    end
    result_next.ray_id = list_data.ray_id;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_hit     <= '0;
      result_valid <= 1'b0;
    end else begin
      if (result_valid & ~result_stall) begin
        result_valid <= 1'b0;
      end
      if (take) begin
        if (list_data.is_last) begin
          result_valid <= 1'b1;
          slot_hit[list_data.ray_id] <= 1'b0;  // Free the slot for the ray's next leaf
        end else if (replace) begin
          slot_hit[list_data.ray_id] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take & ~list_data.is_last & replace) begin
      slot_rec[list_data.ray_id] <= new_rec;
    end
    if (take & list_data.is_last) begin
      result_data <= result_next;
    end
  end

endmodule

// ==== design/int_stage.sv ====
module int_stage (
  input  logic clk,
  input  logic reset,
  input  logic rs_to_int_valid,
  input  int_pkg::rs_to_int_t rs_to_int_data,
  output logic rs_to_int_stall,
  output logic int_to_larb_valid,
  output int_pkg::leaf_info_t int_to_larb_data,
  input  logic int_to_larb_stall,
  output logic result_valid,
  output int_pkg::ray_result_t result_data,
  input  logic result_stall
);

  // Hits and list ends on their way to the collector
  logic int_to_list_valid;
  logic int_to_list_stall;
  int_pkg::int_to_list_t int_to_list_data;

  int_unit int_unit_inst (
    .clk,
    .reset,
    .rs_to_int_valid,
    .rs_to_int_data,
    .rs_to_int_stall,
    .int_to_list_valid,
    .int_to_list_data,
    .int_to_list_stall,
    .int_to_larb_valid,
    .int_to_larb_data,
    .int_to_larb_stall
  );

  hit_list hit_list_inst (
    .clk,
    .reset,
    .list_valid(int_to_list_valid),
    .list_data(int_to_list_data),
    .list_stall(int_to_list_stall),
    .result_stall,
    .result_valid,
    .result_data
  );

endmodule

// ==== test/int_stage_assertions.sv ====
module int_unit_assertions (
  input logic clk,
  input logic reset,
  input logic list_wr,
  input logic list_full,
  input logic larb_wr,
  input logic larb_full,
  input logic rs_to_int_valid,
  input logic rs_to_int_stall,
  input logic int_to_list_valid,
  input logic int_to_larb_valid
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Admission control must keep both FIFOs from overflowing
  assert property (@(posedge clk) disable iff (reset) !(list_wr && list_full))
    else $error("list FIFO written while full");

  assert property (@(posedge clk) disable iff (reset) !(larb_wr && larb_full))
    else $error("larb FIFO written while full");

  assert property (@(posedge clk) disable iff (reset) !(rs_to_int_stall && !rs_to_int_valid))
    else $error("rs_to_int_stall high without a request");

  // Both output streams start out empty
  assert property (@(posedge clk) reset |=> (!int_to_list_valid && !int_to_larb_valid))
    else $error("output valid high right after reset");

endmodule

bind int_unit int_unit_assertions int_unit_assertions_inst (
  .clk,
  .reset,
  .list_wr,
  .list_full,
  .larb_wr,
  .larb_full,
  .rs_to_int_valid,
  .rs_to_int_stall,
  .int_to_list_valid,
  .int_to_larb_valid
);

// ==== test/tb_int_stage.sv ====
module tb_int_stage;

  localparam int CLK_PERIOD     = 20;
  localparam int TOTAL_REQS     = 120;   // Upper bound on requests over all tests
  localparam int CYCLES_PER_REQ = 40;    // Worst case with heavy output stalls
  localparam int MARGIN_CYCLES  = 2000;
  localparam int DRAIN_LIMIT    = 3000;

  logic clk;
  logic reset;
  logic rs_to_int_valid;
  int_pkg::rs_to_int_t rs_to_int_data;
  logic rs_to_int_stall;
  logic int_to_larb_valid;
  int_pkg::leaf_info_t int_to_larb_data;
  logic int_to_larb_stall;
  logic result_valid;
  int_pkg::ray_result_t result_data;
  logic result_stall;

  int error_count;
  int check_count;
  int stall_pct;     // Chance in percent that each output stall is held in a cycle
  int stall_cycles;  // Cycles in which a request was refused

  int_pkg::ray_result_t exp_res[$];
  int_pkg::ray_result_t got_res[$];
  int_pkg::leaf_info_t exp_leaf[$];
  int_pkg::leaf_info_t got_leaf[$];
  int_pkg::int_to_list_t best[int_pkg::RAY_SLOTS];  // Nearest hit so far per ray
  logic best_ok[int_pkg::RAY_SLOTS];

  int_stage int_stage_inst (
    .clk,
    .reset,
    .rs_to_int_valid,
    .rs_to_int_data,
    .rs_to_int_stall,
    .int_to_larb_valid,
    .int_to_larb_data,
    .int_to_larb_stall,
    .result_valid,
    .result_data,
    .result_stall
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Transfers happen at the next rising edge, and nothing moves between here and there
  always @(negedge clk) begin
    if (result_valid && !result_stall) got_res.push_back(result_data);
    if (int_to_larb_valid && !int_to_larb_stall) got_leaf.push_back(int_to_larb_data);
  end

  always @(posedge clk) begin
    #1;
    if (stall_pct > 0) begin
      int_to_larb_stall = ($urandom % 100) < stall_pct;
      result_stall = ($urandom % 100) < stall_pct;
    end else begin
      int_to_larb_stall = 1'b0;
      result_stall = 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  function automatic longint sx(input int_pkg::coord_t c);
    return longint'($signed(c));
  endfunction

  // Ray into triangle space, then t, u and v kept as fractions over one denominator
  function automatic int_pkg::int_to_list_t model_int(input int_pkg::rs_to_int_t q);
    longint m[9];
    longint o[3];
    longint d[3];
    longint tr[3];
    longint so[3];
    longint sd[3];
    longint tn, td, un, vn;
    int_pkg::int_to_list_t e;
    m = '{sx(q.tri_xform.m00), sx(q.tri_xform.m01), sx(q.tri_xform.m02),
          sx(q.tri_xform.m10), sx(q.tri_xform.m11), sx(q.tri_xform.m12),
          sx(q.tri_xform.m20), sx(q.tri_xform.m21), sx(q.tri_xform.m22)};
    tr = '{sx(q.tri_xform.tx), sx(q.tri_xform.ty), sx(q.tri_xform.tz)};
    o = '{sx(q.ray_vec.ox), sx(q.ray_vec.oy), sx(q.ray_vec.oz)};
    d = '{sx(q.ray_vec.dx), sx(q.ray_vec.dy), sx(q.ray_vec.dz)};
    for (int i = 0; i < 3; i++) begin
      so[i] = ((m[3*i] * o[0] + m[3*i+1] * o[1] + m[3*i+2] * o[2]) >>> int_pkg::FRAC_BITS)
            + tr[i];
      sd[i] = (m[3*i] * d[0] + m[3*i+1] * d[1] + m[3*i+2] * d[2]) >>> int_pkg::FRAC_BITS;
    end
    tn = -(so[2] * 256);
    td = sd[2] * 256;
    un = so[0] * sd[2] - so[2] * sd[0];
    vn = so[1] * sd[2] - so[2] * sd[1];
    if (td < 0) begin  // Denominator must end up positive
      tn = -tn;
      td = -td;
      un = -un;
      vn = -vn;
    end
    e = '0;
    e.ray_id = q.ray_id;
    e.tri_id = q.tri_id;
    e.is_last = (q.ln_tri.lnum_left == 8'd1);
    e.hit = (td > 0) && (tn > (td >>> int_pkg::EPS_SHIFT)) && (un >= 0) && (vn >= 0)
         && (un + vn <= td);
    e.t_num = int_pkg::wide_t'(tn);
    e.t_den = int_pkg::wide_t'(td);
    e.u_num = int_pkg::wide_t'(un);
    e.v_num = int_pkg::wide_t'(vn);
    return e;
  endfunction

  // Queues the larb entry and folds the hit into the ray's nearest record
  function automatic void expect_req(input int_pkg::rs_to_int_t q);
    int_pkg::int_to_list_t e;
    int_pkg::leaf_info_t lf;
    int_pkg::ray_result_t r;
    longint new_x, old_x;
    e = model_int(q);
    if (!e.is_last) begin
      lf.ray_id = q.ray_id;
      lf.ln_tri.lnum_left = q.ln_tri.lnum_left - 8'd1;
      lf.ln_tri.lindex = q.ln_tri.lindex + 16'd1;
      exp_leaf.push_back(lf);
    end
    new_x = longint'($signed(e.t_num)) * longint'($signed(best[q.ray_id].t_den));
    old_x = longint'($signed(best[q.ray_id].t_num)) * longint'($signed(e.t_den));
    if (e.hit && (!best_ok[q.ray_id] || new_x < old_x)) begin
      best[q.ray_id] = e;
      best_ok[q.ray_id] = 1'b1;
    end
    if (e.is_last) begin
      r = '0;
      r.ray_id = q.ray_id;
      if (best_ok[q.ray_id]) begin
        r.hit = 1'b1;
        r.tri_id = best[q.ray_id].tri_id;
        r.t_num = best[q.ray_id].t_num;
        r.t_den = best[q.ray_id].t_den;
        r.u_num = best[q.ray_id].u_num;
        r.v_num = best[q.ray_id].v_num;
      end
      exp_res.push_back(r);
      best_ok[q.ray_id] = 1'b0;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus builders
  function automatic int pick(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  function automatic int_pkg::tri_xform_t unit_xform(input int tz);
    int_pkg::tri_xform_t xf;
    xf = '0;
    xf.m00 = 16'sd256;  // Identity in 8.8
    xf.m11 = 16'sd256;
    xf.m22 = 16'sd256;
    xf.tz = int_pkg::coord_t'(tz);
    return xf;
  endfunction

  function automatic int_pkg::ray_vec_t ray_at(input int ox, input int oy, input int oz,
                                                input int dx, input int dy, input int dz);
    int_pkg::ray_vec_t rv;
    rv.ox = int_pkg::coord_t'(ox);
    rv.oy = int_pkg::coord_t'(oy);
    rv.oz = int_pkg::coord_t'(oz);
    rv.dx = int_pkg::coord_t'(dx);
    rv.dy = int_pkg::coord_t'(dy);
    rv.dz = int_pkg::coord_t'(dz);
    return rv;
  endfunction

  function automatic int_pkg::rs_to_int_t make_req(input int ray, input int tri_num,
      input int left, input int idx, input int_pkg::tri_xform_t xf,
      input int_pkg::ray_vec_t rv);
    int_pkg::rs_to_int_t q;
    q.ray_id = int_pkg::ray_id_t'(ray);
    q.tri_id = int_pkg::tri_id_t'(tri_num);
    q.ln_tri.lnum_left = int_pkg::lcount_t'(left);
    q.ln_tri.lindex = int_pkg::lindex_t'(idx);
    q.tri_xform = xf;
    q.ray_vec = rv;
    return q;
  endfunction

  // Near-identity transforms and downward rays, so roughly half of them hit
  function automatic int_pkg::rs_to_int_t rand_req(input int ray, input int tri_num,
                                                    input int left, input int idx);
    int_pkg::tri_xform_t xf;
    xf.m00 = int_pkg::coord_t'(256 + pick(-32, 32));
    xf.m01 = int_pkg::coord_t'(pick(-32, 32));
    xf.m02 = int_pkg::coord_t'(pick(-32, 32));
    xf.m10 = int_pkg::coord_t'(pick(-32, 32));
    xf.m11 = int_pkg::coord_t'(256 + pick(-32, 32));
    xf.m12 = int_pkg::coord_t'(pick(-32, 32));
    xf.m20 = int_pkg::coord_t'(pick(-32, 32));
    xf.m21 = int_pkg::coord_t'(pick(-32, 32));
    xf.m22 = int_pkg::coord_t'(256 + pick(-32, 32));
    xf.tx = int_pkg::coord_t'(pick(-64, 64));
    xf.ty = int_pkg::coord_t'(pick(-64, 64));
    xf.tz = int_pkg::coord_t'(pick(-128, 128));
    return make_req(ray, tri_num, left, idx, xf,
                    ray_at(pick(-32, 288), pick(-32, 288), pick(256, 1024),
                           pick(-64, 64), pick(-64, 64), pick(-320, -128)));
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Driving and checking
  task automatic send_req(input int_pkg::rs_to_int_t q);
    logic accepted;
    rs_to_int_valid = 1'b1;
    rs_to_int_data = q;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = !rs_to_int_stall;
      if (!accepted) stall_cycles++;
      @(posedge clk);
      #1;
    end
    rs_to_int_valid = 1'b0;
    expect_req(q);
  endtask

  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while ((got_res.size() < exp_res.size() || got_leaf.size() < exp_leaf.size())
           && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    repeat (10) @(posedge clk);  // Room for any unexpected extra output
    #1;
    if (cycles >= DRAIN_LIMIT) begin
      error_count++;
      $display("%s: outputs still missing after %0d cycles", name, DRAIN_LIMIT);
    end
  endtask

  task automatic check_result(input string name, input int_pkg::ray_result_t exp,
                              input int_pkg::ray_result_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_leaf(input string name, input int_pkg::leaf_info_t exp,
                            input int_pkg::leaf_info_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_queues(input string name);
    int n;
    if (got_res.size() != exp_res.size() || got_leaf.size() != exp_leaf.size()) begin
      error_count++;
      $display("%s: expected %0d results and %0d larb entries, got %0d and %0d", name,
               exp_res.size(), exp_leaf.size(), got_res.size(), got_leaf.size());
    end
    n = (got_res.size() < exp_res.size()) ? got_res.size() : exp_res.size();
    for (int i = 0; i < n; i++) check_result(name, exp_res[i], got_res[i]);
    n = (got_leaf.size() < exp_leaf.size()) ? got_leaf.size() : exp_leaf.size();
    for (int i = 0; i < n; i++) check_leaf(name, exp_leaf[i], got_leaf[i]);
    exp_res.delete();
    got_res.delete();
    exp_leaf.delete();
    got_leaf.delete();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  task automatic single_hit();
    send_req(make_req(1, 7, 1, 0, unit_xform(0), ray_at(64, 64, 512, 0, 0, -256)));
    wait_drain("single_hit");
    if (got_res.size() == 1 && !got_res[0].hit) begin
      error_count++;
      $display("single_hit: the triangle in front of the ray was not hit");
    end
    compare_queues("single_hit");
  endtask

  task automatic miss_cases();
    send_req(make_req(2, 8, 1, 0, unit_xform(0), ray_at(64, 64, 512, 256, 0, 0)));  // Parallel
    send_req(make_req(5, 9, 1, 0, unit_xform(0), ray_at(192, 192, 512, 0, 0, -256)));
    wait_drain("miss_cases");
    foreach (got_res[i]) begin
      if (got_res[i].hit) begin
        error_count++;
        $display("miss_cases: ray %0d reported a hit", got_res[i].ray_id);
      end
    end
    compare_queues("miss_cases");
  endtask

  task automatic five_deep_list();
    int depth[5];
    depth = '{2, 5, 1, 4, 3};  // Plane height in steps of 0.5, so tri 11 is nearest
    for (int i = 0; i < 5; i++) begin
      send_req(make_req(3, 10 + i, 5 - i, 20 + i, unit_xform(-128 * depth[i]),
                        ray_at(64, 64, 1024, 0, 0, -256)));
    end
    wait_drain("five_deep_list");
    if (got_res.size() == 1 && got_res[0].tri_id != 16'd11) begin
      error_count++;
      $display("five_deep_list: nearest triangle 11 was not chosen");
    end
    compare_queues("five_deep_list");
  endtask

  task automatic stall_stress();
    stall_cycles = 0;
    stall_pct = 85;
    for (int j = 0; j < 8; j++) begin
      for (int r = 0; r < 6; r++) send_req(rand_req(r, 100 + 8 * r + j, 8 - j, j));
    end
    wait_drain("stall_stress");
    stall_pct = 0;
    if (stall_cycles == 0) begin
      error_count++;
      $display("stall_stress: requests were never refused during long output stalls");
    end
    compare_queues("stall_stress");
  endtask

  task automatic random_rays();
    int left[10];
    int sent[10];
    int base[10];
    int pending;
    int r;
    int tri_num;
    pending = 0;
    tri_num = 200;
    stall_pct = 25;
    for (int i = 0; i < 10; i++) begin
      left[i] = pick(1, 6);
      sent[i] = 0;
      base[i] = pick(0, 1000);
      pending += left[i];
    end
    while (pending > 0) begin
      r = pick(0, 9);
      if (sent[r] < left[r]) begin
        send_req(rand_req(r, tri_num, left[r] - sent[r], base[r] + sent[r]));
        sent[r]++;
        tri_num++;
        pending--;
      end
    end
    wait_drain("random_rays");
    stall_pct = 0;
    compare_queues("random_rays");
  endtask

  initial begin
    void'($urandom(32'h62da_4b35));
    clk = 1'b0;
    reset = 1'b1;
    rs_to_int_valid = 1'b0;
    rs_to_int_data = '0;
    int_to_larb_stall = 1'b0;
    result_stall = 1'b0;
    error_count = 0;
    check_count = 0;
    stall_pct = 0;
    stall_cycles = 0;
    foreach (best_ok[i]) best_ok[i] = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    single_hit();
    miss_cases();
    five_deep_list();
    stall_stress();
    random_rays();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #((TOTAL_REQS * CYCLES_PER_REQ + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog: run did not finish in time, %0d errors so far", error_count);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== int_stage.f ====
design/int_pkg.sv
design/int_math.sv
design/pipe_valid_stall.sv
design/sync_fifo.sv
design/int_unit.sv
design/hit_list.sv
design/int_stage.sv
test/int_stage_assertions.sv
test/tb_int_stage.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_int_stage and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_int_stage \
		-f int_stage.f -Mdir obj_dir -o sim_int_stage
	./obj_dir/sim_int_stage | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
